// ==== src/mult_pkg.sv ====
/*
 * multiplier arithmetic constants
 * operand and product widths, signedness and the depth of the
 * multiplier pipeline, shared by the RTL and the testbench
 */
package mult_pkg;

    // width of each operand in bits
    localparam int INPUT_WIDTH = 16;

    // a full product never overflows at twice the operand width
    localparam int OUTPUT_WIDTH = 2 * INPUT_WIDTH;

    // when set, operands and product are treated as two's complement
    // and the multiplier sign-extends both inputs
    localparam bit IS_SIGNED = 1'b1;

    // register stages in the multiplier
    // stage 0 holds the operands, stage 1 the raw product and the
    // rest only carry the product forward to ease timing
    localparam int PIPE_STAGES = 3;

endpackage

// ==== src/axis_pkg.sv ====
/*
 * stream payload definitions
 * operand, operand pair and product payloads carried over the
 * valid/ready links, plus stream-level constants
 */
package axis_pkg;

    // number of operand streams the join synchronizes
    localparam int NUM_OPERANDS = 2;

    // one operand as it travels on an input stream
    typedef logic [mult_pkg::INPUT_WIDTH-1:0] operand_t;

    // both operands of one multiplication, packed side by side
    // a sits in the upper half, b in the lower half
    typedef struct packed {
        operand_t a;
        operand_t b;
    } operand_pair_t;

    // one product on the output stream
    typedef logic [mult_pkg::OUTPUT_WIDTH-1:0] product_t;

endpackage

// ==== src/axis_skid_buffer.sv ====
/*
 * stream skid buffer
 * two-entry register slice for a valid/ready link, full throughput
 * with in_ready driven straight from a flop
 */
module axis_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // main register feeds the output, spill catches one beat under stall
    logic     main_valid;
    logic     spill_valid;
    payload_t main_data;
    payload_t spill_data;

    logic accept;
    logic pop;
    logic main_load_in;
    logic main_load_spill;
    logic spill_load;

    // ready only looks at the spill flag, so out_ready never reaches in_ready
    assign in_ready  = !spill_valid;
    assign out_valid = main_valid;
    assign out_data  = main_data;

    assign accept = in_valid && in_ready;
    assign pop    = main_valid && out_ready;

    // an accepted beat goes straight to main when main is free or draining
    // (spill is always empty when a beat is accepted)
    assign main_load_in    = accept && (!main_valid || out_ready);
    // once main drains, a waiting spill beat moves up
    assign main_load_spill = pop && spill_valid;
    // main is held by the consumer, so the new beat parks in spill
    assign spill_load      = accept && main_valid && !out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else begin
            if (main_load_in || main_load_spill) begin
                main_valid <= 1'b1;
            end else if (pop) begin
                main_valid <= 1'b0;
            end

            if (spill_load) begin
                spill_valid <= 1'b1;
            end else if (main_load_spill) begin
                spill_valid <= 1'b0;
            end
        end
    end

    // payload registers follow the load enables above
    always_ff @(posedge clk) begin
        if (main_load_spill) begin
            main_data <= spill_data;
        end else if (main_load_in) begin
            main_data <= in_data;
        end

        if (spill_load) begin
            spill_data <= in_data;
        end
    end

endmodule

// ==== src/axis_join.sv ====
/*
 * operand stream join
 * pairs two independent operand streams so that both operands move
 * together as one transfer, never one without the other
 */
module axis_join (
    input  logic                    a_valid,
    output logic                    a_ready,
    input  axis_pkg::operand_t      a_data,
    input  logic                    b_valid,
    output logic                    b_ready,
    input  axis_pkg::operand_t      b_data,
    output logic                    pair_valid,
    input  logic                    pair_ready,
    output axis_pkg::operand_pair_t pair_data
);

    // collected valids of all operand streams, a in bit 0 and b in bit 1
    logic [axis_pkg::NUM_OPERANDS-1:0] valids;

    assign valids = {b_valid, a_valid};

    // a pair exists only once every stream has a beat waiting
    assign pair_valid = &valids;

    // each side is released only if the other side goes in the same cycle,
    // which keeps the two streams in lock step
    // valids never look at any ready here, so no loop forms through the join
    assign a_ready = pair_ready && valids[1];
    assign b_ready = pair_ready && valids[0];

    // pack the operands in the order the pipeline expects
    assign pair_data.a = a_data;
    assign pair_data.b = b_data;

endmodule

// ==== src/mult_pipeline.sv ====
/*
 * stalling multiplier pipeline
 * registers the operand pair, multiplies it and carries the product
 * through the remaining stages, all stages frozen by one stall
 */
module mult_pipeline (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pair_valid,
    output logic                    pair_ready,
    input  axis_pkg::operand_pair_t pair_data,
    output logic                    prod_valid,
    input  logic                    prod_ready,
    output axis_pkg::product_t      prod_data
);

    // one valid bit per stage, stage 0 is the operand register
    logic [mult_pkg::PIPE_STAGES-1:0] valid_q;

    // stage 0 operands
    axis_pkg::operand_t a_q;
    axis_pkg::operand_t b_q;

    // product registers for stage 1 onwards
    axis_pkg::product_t prod_q [1:mult_pkg::PIPE_STAGES-1];

    // combinational product of the stage 0 operands
    axis_pkg::product_t mult_result;

    logic advance;

    // the whole pipe moves when the last stage is empty or being drained
    // bubbles in earlier stages are not squeezed out, which keeps the
    // stall a single global enable
    assign advance    = !valid_q[mult_pkg::PIPE_STAGES-1] || prod_ready;
    assign pair_ready = advance;

    assign prod_valid = valid_q[mult_pkg::PIPE_STAGES-1];
    assign prod_data  = prod_q[mult_pkg::PIPE_STAGES-1];

    // signedness is fixed at elaboration
    generate
        if (mult_pkg::IS_SIGNED) begin : g_signed
            // both operands signed, so the product is sign-extended to full width
            assign mult_result = $signed(a_q) * $signed(b_q);
        end else begin : g_unsigned
            assign mult_result = a_q * b_q;
        end
    endgenerate

    // valid bits shift one stage per advance
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q[0] <= pair_valid;
            for (int i = 1; i < mult_pkg::PIPE_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // data registers move with the same enable as the valid bits
    always_ff @(posedge clk) begin
        if (advance) begin
            a_q       <= pair_data.a;
            b_q       <= pair_data.b;
            prod_q[1] <= mult_result;
            for (int i = 2; i < mult_pkg::PIPE_STAGES; i++) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

endmodule

// ==== src/mult_top.sv ====
/*
 * streaming multiplier top level
 * two operand streams in, one product stream out, built from input
 * and output skid buffers, a join and the multiplier pipeline
 */
module mult_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in0_tvalid,
    output logic               in0_tready,
    input  axis_pkg::operand_t in0_tdata,
    input  logic               in1_tvalid,
    output logic               in1_tready,
    input  axis_pkg::operand_t in1_tdata,
    output logic               out_tvalid,
    input  logic               out_tready,
    output axis_pkg::product_t out_tdata
);

    // registered operand streams into the join
    logic               a_valid;
    logic               a_ready;
    axis_pkg::operand_t a_data;
    logic               b_valid;
    logic               b_ready;
    axis_pkg::operand_t b_data;

    // joined pairs into the multiplier
    logic                    pair_valid;
    logic                    pair_ready;
    axis_pkg::operand_pair_t pair_data;

    // products into the output slice
    logic               prod_valid;
    logic               prod_ready;
    axis_pkg::product_t prod_data;

    // input slices cut the ready path back to the operand sources
    axis_skid_buffer #(.payload_t(axis_pkg::operand_t)) in0_slice (
        .clk(clk), .reset(reset),
        .in_valid(in0_tvalid), .in_ready(in0_tready), .in_data(in0_tdata),
        .out_valid(a_valid), .out_ready(a_ready), .out_data(a_data)
    );

    axis_skid_buffer #(.payload_t(axis_pkg::operand_t)) in1_slice (
        .clk(clk), .reset(reset),
        .in_valid(in1_tvalid), .in_ready(in1_tready), .in_data(in1_tdata),
        .out_valid(b_valid), .out_ready(b_ready), .out_data(b_data)
    );

    axis_join u_join (
        .a_valid(a_valid), .a_ready(a_ready), .a_data(a_data),
        .b_valid(b_valid), .b_ready(b_ready), .b_data(b_data),
        .pair_valid(pair_valid), .pair_ready(pair_ready), .pair_data(pair_data)
    );

    mult_pipeline u_pipeline (
        .clk(clk), .reset(reset),
        .pair_valid(pair_valid), .pair_ready(pair_ready), .pair_data(pair_data),
        .prod_valid(prod_valid), .prod_ready(prod_ready), .prod_data(prod_data)
    );

    // output slice keeps out_tready off the pipeline stall path
    axis_skid_buffer #(.payload_t(axis_pkg::product_t)) out_slice (
        .clk(clk), .reset(reset),
        .in_valid(prod_valid), .in_ready(prod_ready), .in_data(prod_data),
        .out_valid(out_tvalid), .out_ready(out_tready), .out_data(out_tdata)
    );

endmodule

// ==== bench/mult_checker.sv ====
/*
 * product stream checker
 * concurrent assertions on the output handshake and on reset state,
 * bound into every instance of the multiplier top level
 */
module mult_checker (
    input logic               clk,
    input logic               reset,
    input logic               in0_tready,
    input logic               in1_tready,
    input logic               out_tvalid,
    input logic               out_tready,
    input axis_pkg::product_t out_tdata
);

    // running count of failed assertions
    int failures = 0;

    // a stalled product stays on the bus unchanged until it is taken
    property hold_while_stalled;
        @(posedge clk) disable iff (reset)
            out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata);
    endproperty

    // the synchronous reset empties the output slice by the next cycle
    property quiet_after_reset;
        @(posedge clk) reset |=> !out_tvalid;
    endproperty

    // both input slices leave reset with an empty spill register
    property ready_after_reset;
        @(posedge clk) $fell(reset) |-> in0_tready && in1_tready;
    endproperty

    stall_hold_a: assert property (hold_while_stalled)
        else begin
            failures++;
            $error("product changed or vanished while out_tready was low");
        end

    reset_quiet_a: assert property (quiet_after_reset)
        else begin
            failures++;
            $error("out_tvalid high in the cycle after reset");
        end

    reset_ready_a: assert property (ready_after_reset)
        else begin
            failures++;
            $error("input ready low on the first edge after reset");
        end

endmodule

// every multiplier top level carries its own copy of the checks
bind mult_top mult_checker stream_checks (
    .clk(clk), .reset(reset),
    .in0_tready(in0_tready), .in1_tready(in1_tready),
    .out_tvalid(out_tvalid), .out_tready(out_tready), .out_tdata(out_tdata)
);

// ==== bench/mult_tb.sv ====
/*
 * testbench for the streaming multiplier
 * directed tests drive both operand streams and the output ready,
 * a monitor compares every product with a queue of expected values
 */
module mult_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    // input slice, the multiplier stages and the output slice
    localparam int LATENCY      = 1 + mult_pkg::PIPE_STAGES + 1;
    localparam int CORNER_PAIRS = 10;
    localparam int STREAM_PAIRS = 50;
    localparam int STALL_PAIRS  = 300;
    localparam int SKEW_PAIRS   = 8;
    localparam int SKEW_DELAY   = 6;
    localparam int RESET_PAIRS  = 20;
    localparam int FRESH_PAIRS  = 8;
    localparam int TOTAL_PAIRS  = CORNER_PAIRS + STREAM_PAIRS + STALL_PAIRS
                                + 2 * SKEW_PAIRS + RESET_PAIRS + FRESH_PAIRS;
    localparam longint TIMEOUT  = longint'(TOTAL_PAIRS * 40 + 2 * RESET_CYCLES) * CLK_PERIOD;

    localparam axis_pkg::operand_t MAX_POS  = {1'b0, {(mult_pkg::INPUT_WIDTH-1){1'b1}}};
    localparam axis_pkg::operand_t MIN_NEG  = {1'b1, {(mult_pkg::INPUT_WIDTH-1){1'b0}}};
    localparam axis_pkg::operand_t ALL_ONES = '1;
    localparam axis_pkg::operand_t ONE      = 1;

    logic               clk = 1'b0;
    logic               reset;
    logic               in0_tvalid;
    logic               in0_tready;
    axis_pkg::operand_t in0_tdata;
    logic               in1_tvalid;
    logic               in1_tready;
    axis_pkg::operand_t in1_tdata;
    logic               out_tvalid;
    logic               out_tready;
    axis_pkg::product_t out_tdata;

    // operands still to send and products still to arrive, in order
    axis_pkg::operand_t in0_pending[$];
    axis_pkg::operand_t in1_pending[$];
    axis_pkg::product_t exp_q[$];

    // idle cycles before each stream starts presenting its operands
    int in0_delay = 0;
    int in1_delay = 0;
    bit ready_random = 1'b0;
    bit in0_fire = 1'b0;
    bit in1_fire = 1'b0;

    // cycle stamps and counters kept by the monitor
    int cycle = 0;
    int first_in0, first_in1, first_out, last_out, out_gaps, out_count;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int test_checks, test_errors;

    mult_top dut (
        .clk(clk), .reset(reset),
        .in0_tvalid(in0_tvalid), .in0_tready(in0_tready), .in0_tdata(in0_tdata),
        .in1_tvalid(in1_tvalid), .in1_tready(in1_tready), .in1_tdata(in1_tdata),
        .out_tvalid(out_tvalid), .out_tready(out_tready), .out_tdata(out_tdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // product of two operands, signed or unsigned as the package says
    function automatic axis_pkg::product_t expected_product(
        input axis_pkg::operand_t a, input axis_pkg::operand_t b);
        longint sa;
        longint sb;
        if (mult_pkg::IS_SIGNED) begin
            sa = longint'($signed(a));
            sb = longint'($signed(b));
        end else begin
            sa = longint'(a);
            sb = longint'(b);
        end
        return axis_pkg::product_t'(sa * sb);
    endfunction

    function automatic axis_pkg::operand_t random_operand();
        return axis_pkg::operand_t'($urandom);
    endfunction

    task automatic queue_pair(input axis_pkg::operand_t a, input axis_pkg::operand_t b);
        in0_pending.push_back(a);
        in1_pending.push_back(b);
        exp_q.push_back(expected_product(a, b));
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    task automatic clear_trackers();
        first_in0 = -1;
        first_in1 = -1;
        first_out = -1;
        out_gaps  = 0;
        out_count = 0;
    endtask

    // setup happens on a rising edge, the drivers pick it up at the next falling one
    task automatic start_test();
        @(posedge clk);
        test_checks = checks;
        test_errors = errors;
        clear_trackers();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %s finished: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic check_output(input axis_pkg::product_t got);
        axis_pkg::product_t want;
        checks++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("** Error at %0t: product %h arrived with nothing pending", $time, got);
        end else begin
            want = exp_q.pop_front();
            if (got !== want) begin
                errors++;
                $display("** Error at %0t: product %h, expected %h", $time, got, want);
            end
        end
        if (first_out < 0) begin
            first_out = cycle;
        end else if (cycle != last_out + 1) begin
            out_gaps++;
        end
        last_out = cycle;
        out_count++;
    endtask

    // monitor samples handshakes on the rising edge, before any flop updates
    always @(posedge clk) begin
        cycle++;
        in0_fire = 1'b0;
        in1_fire = 1'b0;
        if (!reset) begin
            in0_fire = in0_tvalid && in0_tready;
            in1_fire = in1_tvalid && in1_tready;
            if (in0_fire && first_in0 < 0) first_in0 = cycle;
            if (in1_fire && first_in1 < 0) first_in1 = cycle;
            if (out_tvalid && out_tready) check_output(out_tdata);
        end
    end

    // drivers change inputs on the falling edge and hold a valid beat until it is taken
    always @(negedge clk) begin
        if (reset) begin
            in0_tvalid = 1'b0;
            in1_tvalid = 1'b0;
        end else begin
            if (in0_fire && in0_pending.size() > 0) in0_pending.delete(0);
            if (in1_fire && in1_pending.size() > 0) in1_pending.delete(0);
            if (in0_pending.size() == 0) begin
                in0_tvalid = 1'b0;
            end else if (in0_delay > 0) begin
                in0_delay--;
                in0_tvalid = 1'b0;
            end else begin
                in0_tvalid = 1'b1;
                in0_tdata  = in0_pending[0];
            end
            if (in1_pending.size() == 0) begin
                in1_tvalid = 1'b0;
            end else if (in1_delay > 0) begin
                in1_delay--;
                in1_tvalid = 1'b0;
            end else begin
                in1_tvalid = 1'b1;
                in1_tdata  = in1_pending[0];
            end
        end
        out_tready = ready_random ? ($urandom % 2 == 1) : 1'b1;
    end

    task automatic test_corner_products();
        axis_pkg::operand_t a_list [CORNER_PAIRS];
        axis_pkg::operand_t b_list [CORNER_PAIRS];
        a_list = '{'0, '0, ONE, ONE, MAX_POS, MIN_NEG, MAX_POS, ALL_ONES, ALL_ONES, MAX_POS};
        b_list = '{'0, MAX_POS, ONE, MIN_NEG, MAX_POS, MIN_NEG, MIN_NEG, ALL_ONES, MIN_NEG,
                   ALL_ONES};
        start_test();
        for (int i = 0; i < CORNER_PAIRS; i++) queue_pair(a_list[i], b_list[i]);
        wait_drain();
        checks++;
        if (out_count != CORNER_PAIRS) report_failure("corner products missing");
        finish_test("corner_products");
    endtask

    task automatic test_latency_throughput();
        start_test();
        for (int i = 0; i < STREAM_PAIRS; i++) queue_pair(random_operand(), random_operand());
        wait_drain();
        checks++;
        if (first_out - first_in0 != LATENCY) begin
            report_failure($sformatf("first product after %0d cycles, expected %0d",
                                     first_out - first_in0, LATENCY));
        end
        checks++;
        if (out_gaps != 0 || out_count != STREAM_PAIRS) begin
            report_failure($sformatf("%0d products with %0d gaps in a full-rate stream",
                                     out_count, out_gaps));
        end
        finish_test("latency_throughput");
    endtask

    task automatic test_back_pressure();
        start_test();
        ready_random = 1'b1;
        for (int i = 0; i < STALL_PAIRS; i++) queue_pair(random_operand(), random_operand());
        wait_drain();
        ready_random = 1'b0;
        checks++;
        if (out_count != STALL_PAIRS) report_failure("product count wrong under back-pressure");
        finish_test("back_pressure");
    endtask

    // one stream starts late, the pair must wait for it
    task automatic skew_round(input int delay0, input int delay1);
        int late;
        @(posedge clk);
        clear_trackers();
        in0_delay = delay0;
        in1_delay = delay1;
        for (int i = 0; i < SKEW_PAIRS; i++) queue_pair(random_operand(), random_operand());
        wait_drain();
        late = (first_in0 > first_in1) ? first_in0 : first_in1;
        checks++;
        if (first_out - late != LATENCY) begin
            report_failure($sformatf("product %0d cycles after the late operand, expected %0d",
                                     first_out - late, LATENCY));
        end
    endtask

    task automatic test_skewed_arrival();
        start_test();
        skew_round(0, SKEW_DELAY);
        skew_round(SKEW_DELAY, 0);
        finish_test("skewed_arrival");
    endtask

    task automatic test_reset_midstream();
        int outs_before;
        start_test();
        for (int i = 0; i < RESET_PAIRS; i++) queue_pair(random_operand(), random_operand());
        while (out_count < 3) @(negedge clk);
        // pull reset with the rest of the stream still in flight
        reset = 1'b1;
        in0_pending.delete();
        in1_pending.delete();
        exp_q.delete();
        repeat (4) @(negedge clk);
        checks++;
        if (out_tvalid !== 1'b0) report_failure("out_tvalid still high during reset");
        reset = 1'b0;
        outs_before = out_count;
        repeat (20) @(negedge clk);
        checks++;
        if (out_count != outs_before) report_failure("stale product after reset");
        @(posedge clk);
        for (int i = 0; i < FRESH_PAIRS; i++) queue_pair(random_operand(), random_operand());
        wait_drain();
        checks++;
        if (out_count - outs_before != FRESH_PAIRS) report_failure("fresh products missing");
        finish_test("reset_midstream");
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: tests still running after %0t time units", TIMEOUT);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hcfe9b329));
        reset      = 1'b1;
        in0_tvalid = 1'b0;
        in0_tdata  = '0;
        in1_tvalid = 1'b0;
        in1_tdata  = '0;
        out_tready = 1'b1;
        clear_trackers();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        test_corner_products();
        test_latency_throughput();
        test_back_pressure();
        test_skewed_arrival();
        test_reset_midstream();
        errors = errors + dut.stream_checks.failures;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/mult_pkg.sv
src/axis_pkg.sv
src/axis_skid_buffer.sv
src/axis_join.sv
src/mult_pipeline.sv
src/mult_top.sv
bench/mult_checker.sv
bench/mult_tb.sv

// ==== Bender.yml ====
package:
  name: stream_mult

sources:
  # packages first, axis_pkg uses the mult_pkg widths
  - src/mult_pkg.sv
  - src/axis_pkg.sv
  - src/axis_skid_buffer.sv
  - src/axis_join.sv
  - src/mult_pipeline.sv
  - src/mult_top.sv

  - target: test
    files:
      - bench/mult_checker.sv
      - bench/mult_tb.sv
